// File: design/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// total bytes of the data memory
`define MEM_SIZE     8192

// byte-wide banks striped by the low address bits
`define NUM_BANKS    16
`define BANK_SEL_W   4

// row address inside one bank
`define ROW_W        9

// one access moves an 8-byte little-endian word
`define WORD_BYTES   8
`define BYTE_W       8

`define ADDR_W       64

`endif

// File: design/mem_pkg.sv
`include "mem_config.svh"

package mem_pkg;

    typedef enum logic [1:0]
    {
        OP_IDLE  = 2'd0,
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } memOp_e;

    // request as driven by the outside every cycle
    typedef struct packed
    {
        memOp_e                             op;
        logic [`ADDR_W-1:0]                 addr;
        logic [`WORD_BYTES*`BYTE_W-1:0]     wdata;
    } memReq_t;

    // travels beside a read through the pipe
    typedef struct packed
    {
        logic                               valid;
        logic [`BANK_SEL_W-1:0]             offset;
        logic                               err;
    } alignTag_t;

    // one row, one write byte and one enable per bank
    typedef struct packed
    {
        logic [`NUM_BANKS-1:0][`ROW_W-1:0]  row;
        logic [`NUM_BANKS-1:0]              wen;
        logic [`NUM_BANKS-1:0][`BYTE_W-1:0] wbyte;
        alignTag_t                          tag;
    } bankCmd_t;

    typedef struct packed
    {
        logic [`NUM_BANKS-1:0][`BYTE_W-1:0] rbyte;
        alignTag_t                          tag;
    } bankData_t;

    typedef struct packed
    {
        logic [`WORD_BYTES*`BYTE_W-1:0]     data;
        logic                               err;
    } memRsp_t;

endpackage

// File: design/memAddrDecode.sv
`include "mem_config.svh"

module memAddrDecode
(
    input  logic                i_clk,
    input  logic                i_rstN,
    input  mem_pkg::memReq_t    i_req,
    output mem_pkg::bankCmd_t   o_cmd
);

    // byte index inside the word
    localparam int WORD_SEL_W = $clog2(`WORD_BYTES);

    logic [`ADDR_W:0]       lastByte;
    logic                   err;
    logic                   isWrite;
    logic [`BANK_SEL_W-1:0] offset;
    logic [`ROW_W-1:0]      baseRow;
    logic [`ROW_W-1:0]      nextRow;
    mem_pkg::bankCmd_t      cmdD;

    //////////////////////////////////////////////////////////////////////
    // bounds check and address split
    //////////////////////////////////////////////////////////////////////

    // one extra bit so a huge address cannot wrap below the limit
    assign lastByte = {1'b0, i_req.addr} + (`WORD_BYTES - 1);

    assign err = (i_req.op != mem_pkg::OP_IDLE) && (lastByte >= `MEM_SIZE);

    assign isWrite = (i_req.op == mem_pkg::OP_WRITE) && !err;

    assign offset  = i_req.addr[`BANK_SEL_W-1:0];
    assign baseRow = i_req.addr[`BANK_SEL_W +: `ROW_W];
    assign nextRow = baseRow + 1'b1;

    //////////////////////////////////////////////////////////////////////
    // per-bank row, write lane and enable
    //////////////////////////////////////////////////////////////////////

    genvar b;
    for (b = 0; b < `NUM_BANKS; b++)
    begin : g_bank
        localparam logic [`BANK_SEL_W-1:0] BANK_ID = b;

        logic [`BANK_SEL_W-1:0] lane;

        // word byte that lands in this bank modulo 16
        assign lane = BANK_ID - offset;

        // banks below the start bank hold the tail of a crossing word
        assign cmdD.row[b] = (BANK_ID < offset) ? nextRow : baseRow;

        assign cmdD.wen[b] = isWrite && (lane < `WORD_BYTES);

        assign cmdD.wbyte[b] = i_req.wdata[lane[WORD_SEL_W-1:0]*`BYTE_W +: `BYTE_W];
    end

    // only reads come back out of the pipe
    assign cmdD.tag.valid  = (i_req.op == mem_pkg::OP_READ);
    assign cmdD.tag.offset = offset;
    assign cmdD.tag.err    = err;

    //////////////////////////////////////////////////////////////////////
    // stage 1 register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        o_cmd <= cmdD;
        if (!i_rstN)
        begin
            o_cmd.wen       <= '0;
            o_cmd.tag.valid <= 1'b0;
        end
    end

endmodule

// File: design/memBankArray.sv
`include "mem_config.svh"

module memBankArray
#(
    parameter int ROWS = `MEM_SIZE / `NUM_BANKS
)
(
    input  logic                i_clk,
    input  logic                i_rstN,
    input  mem_pkg::bankCmd_t   i_cmd,
    output mem_pkg::bankData_t  o_data
);

    logic [`NUM_BANKS-1:0][`BYTE_W-1:0] rdByte;
    mem_pkg::alignTag_t                 tagQ;

    //////////////////////////////////////////////////////////////////////
    // byte banks
    //////////////////////////////////////////////////////////////////////

    genvar b;
    for (b = 0; b < `NUM_BANKS; b++)
    begin : g_bank
        logic [`BYTE_W-1:0] mem [ROWS];
        logic [`BYTE_W-1:0] rdQ;

        always_ff @(posedge i_clk)
        begin
            if (i_cmd.wen[b])
            begin
                mem[i_cmd.row[b]] <= i_cmd.wbyte[b];
            end
            // registered read of the addressed row
            rdQ <= mem[i_cmd.row[b]];
        end

        assign rdByte[b] = rdQ;
    end

    //////////////////////////////////////////////////////////////////////
    // tag follows the read by one cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        tagQ <= i_cmd.tag;
        if (!i_rstN)
        begin
            tagQ.valid <= 1'b0;
        end
    end

    assign o_data.rbyte = rdByte;
    assign o_data.tag   = tagQ;

endmodule

// File: design/memReadAlign.sv
`include "mem_config.svh"

module memReadAlign
(
    input  logic                i_clk,
    input  logic                i_rstN,
    input  mem_pkg::bankData_t  i_data,
    output mem_pkg::memRsp_t    o_rsp,
    output logic                o_rspValid
);

    logic [`WORD_BYTES*`BYTE_W-1:0] word;

    //////////////////////////////////////////////////////////////////////
    // rotate bank bytes into word order
    //////////////////////////////////////////////////////////////////////

    genvar k;
    for (k = 0; k < `WORD_BYTES; k++)
    begin : g_byte
        localparam logic [`BANK_SEL_W-1:0] BYTE_ID = k;

        logic [`BANK_SEL_W-1:0] sel;

        // wraps past bank 15 back to bank 0
        assign sel = i_data.tag.offset + BYTE_ID;

        assign word[k*`BYTE_W +: `BYTE_W] = i_data.rbyte[sel];
    end

    //////////////////////////////////////////////////////////////////////
    // stage 3 register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        // out of range reads return zero
        o_rsp.data <= i_data.tag.err ? '0 : word;
        o_rsp.err  <= i_data.tag.err;
        if (!i_rstN)
        begin
            o_rspValid <= 1'b0;
        end
        else
        begin
            o_rspValid <= i_data.tag.valid;
        end
    end

endmodule

// File: design/byteMemory.sv
module byteMemory
(
    input  logic                i_clk,
    input  logic                i_rstN,
    input  mem_pkg::memReq_t    i_req,
    output mem_pkg::memRsp_t    o_rsp,
    output logic                o_rspValid
);

    // stage 1 to stage 2
    mem_pkg::bankCmd_t  bankCmd;

    // stage 2 to stage 3
    mem_pkg::bankData_t bankData;

    //////////////////////////////////////////////////////////////////////
    // stage 1 decode
    //////////////////////////////////////////////////////////////////////

    memAddrDecode u_addrDecode
    (
        .i_clk      (i_clk),
        .i_rstN     (i_rstN),
        .i_req      (i_req),
        .o_cmd      (bankCmd)
    );

    //////////////////////////////////////////////////////////////////////
    // stage 2 banks
    //////////////////////////////////////////////////////////////////////

    memBankArray u_bankArray
    (
        .i_clk      (i_clk),
        .i_rstN     (i_rstN),
        .i_cmd      (bankCmd),
        .o_data     (bankData)
    );

    //////////////////////////////////////////////////////////////////////
    // stage 3 align
    //////////////////////////////////////////////////////////////////////

    memReadAlign u_readAlign
    (
        .i_clk      (i_clk),
        .i_rstN     (i_rstN),
        .i_data     (bankData),
        .o_rsp      (o_rsp),
        .o_rspValid (o_rspValid)
    );

endmodule

// File: verif/byteMemory_props.sv
module byteMemory_props
(
    input  logic                i_clk,
    input  logic                i_rstN,
    input  mem_pkg::memReq_t    i_req,
    input  mem_pkg::memRsp_t    o_rsp,
    input  logic                o_rspValid
);

    timeunit 1ns;
    timeprecision 1ps;

    // running count of assertion failures
    int failCount = 0;

    // every read comes back three sampled cycles later
    a_readResponds: assert property (@(posedge i_clk) disable iff (!i_rstN)
        (i_req.op == mem_pkg::OP_READ) |-> ##3 o_rspValid)
    else
    begin
        $error("read request got no response three cycles later");
        failCount++;
    end

    // no response without a read three cycles earlier
    a_noStrayResponse: assert property (@(posedge i_clk) disable iff (!i_rstN)
        o_rspValid |-> ($past(i_req.op, 3) == mem_pkg::OP_READ))
    else
    begin
        $error("response appeared without a matching read");
        failCount++;
    end

    a_errDataZero: assert property (@(posedge i_clk) disable iff (!i_rstN)
        (o_rspValid && o_rsp.err) |-> (o_rsp.data == '0))
    else
    begin
        $error("error response carries nonzero data");
        failCount++;
    end

endmodule

bind byteMemory byteMemory_props u_props
(
    .i_clk      (i_clk),
    .i_rstN     (i_rstN),
    .i_req      (i_req),
    .o_rsp      (o_rsp),
    .o_rspValid (o_rspValid)
);

// File: verif/byteMemory_tb.sv
`include "mem_config.svh"

module byteMemory_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // several times the cycles all tests take together
    localparam int TIMEOUT_CYCLES = 3000;

    // window used by the random test
    localparam int RAND_BASE = 4096;
    localparam int RAND_SPAN = 256;

    logic               i_clk;
    logic               i_rstN;
    mem_pkg::memReq_t   i_req;
    mem_pkg::memRsp_t   o_rsp;
    logic               o_rspValid;

    logic [`BYTE_W-1:0] refMem [`MEM_SIZE];
    int                 errCount;
    int                 checkCount;
    int                 cycleCount;

    byteMemory DUT
    (
        .i_clk      (i_clk),
        .i_rstN     (i_rstN),
        .i_req      (i_req),
        .o_rsp      (o_rsp),
        .o_rspValid (o_rspValid)
    );

    always
    begin
        #5;
        i_clk = ~i_clk;
    end

    always @(posedge i_clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic outOfRange(input logic [`ADDR_W-1:0] addr);
        return (addr + (`WORD_BYTES - 1)) >= `MEM_SIZE;
    endfunction

    function automatic void modelWrite(input logic [`ADDR_W-1:0] addr, input logic [63:0] data);
        if (!outOfRange(addr))
        begin
            for (int k = 0; k < `WORD_BYTES; k++)
            begin
                refMem[addr + k] = data[k*`BYTE_W +: `BYTE_W];
            end
        end
    endfunction

    // byte k of the word comes from addr + k
    function automatic logic [63:0] modelRead(input logic [`ADDR_W-1:0] addr);
        logic [63:0] data;
        for (int k = 0; k < `WORD_BYTES; k++)
        begin
            data[k*`BYTE_W +: `BYTE_W] = refMem[addr + k];
        end
        return data;
    endfunction

    function automatic mem_pkg::memReq_t makeReq(input mem_pkg::memOp_e op,
                                                 input logic [`ADDR_W-1:0] addr,
                                                 input logic [63:0] wdata);
        mem_pkg::memReq_t req;
        req.op    = op;
        req.addr  = addr;
        req.wdata = wdata;
        return req;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // drive and check
    //////////////////////////////////////////////////////////////////////

    task automatic sendReq(input mem_pkg::memOp_e op, input logic [`ADDR_W-1:0] addr,
                           input logic [63:0] wdata);
        @(posedge i_clk);
        i_req <= makeReq(op, addr, wdata);
        if (op == mem_pkg::OP_WRITE)
        begin
            modelWrite(addr, wdata);
        end
    endtask

    task automatic sendIdle();
        @(posedge i_clk);
        i_req.op <= mem_pkg::OP_IDLE;
    endtask

    task automatic checkRsp(input logic [63:0] expData, input logic expErr);
        checkCount++;
        assert (o_rspValid === 1'b1) else
        begin
            $display("FAIL %0t o_rspValid expected 1 got %b", $time, o_rspValid);
            errCount++;
        end
        assert (o_rsp.err === expErr) else
        begin
            $display("FAIL %0t o_rsp.err expected %b got %b", $time, expErr, o_rsp.err);
            errCount++;
        end
        assert (o_rsp.data === expData) else
        begin
            $display("FAIL %0t o_rsp.data expected %h got %h", $time, expData, o_rsp.data);
            errCount++;
        end
    endtask

    task automatic checkNoRsp();
        checkCount++;
        assert (o_rspValid === 1'b0) else
        begin
            $display("FAIL %0t o_rspValid expected 0 got %b", $time, o_rspValid);
            errCount++;
        end
    endtask

    task automatic writeWord(input logic [`ADDR_W-1:0] addr, input logic [63:0] data);
        sendReq(mem_pkg::OP_WRITE, addr, data);
        sendIdle();
    endtask

    // response shows after the third edge following the drive edge
    task automatic readExpect(input logic [`ADDR_W-1:0] addr);
        logic [63:0] expData;
        logic        expErr;
        expErr  = outOfRange(addr);
        expData = expErr ? '0 : modelRead(addr);
        sendReq(mem_pkg::OP_READ, addr, '0);
        sendIdle();
        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        checkRsp(expData, expErr);
    endtask

    task automatic reportTest(input string name, input int errStart);
        $display("%-14s done, %0d errors", name, errCount - errStart);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic testResetAligned();
        int errStart;
        errStart = errCount;
        repeat (5)
        begin
            @(negedge i_clk);
            checkNoRsp();
        end
        writeWord(64'h40, 64'h0123_4567_89ab_cdef);
        readExpect(64'h40);
        reportTest("reset_aligned", errStart);
    endtask

    task automatic testUnaligned();
        int errStart;
        errStart = errCount;
        writeWord(64'h201, {$urandom, $urandom});
        readExpect(64'h201);
        writeWord(64'h218, {$urandom, $urandom});
        readExpect(64'h218);
        // banks 13..15 then 0..4 of the next row
        writeWord(64'h22d, {$urandom, $urandom});
        readExpect(64'h22d);
        reportTest("unaligned", errStart);
    endtask

    task automatic testOverlap();
        int errStart;
        errStart = errCount;
        writeWord(64'h305, 64'h1111_2222_3333_4444);
        writeWord(64'h308, 64'haaaa_bbbb_cccc_dddd);
        readExpect(64'h305);
        readExpect(64'h308);
        reportTest("overlap", errStart);
    endtask

    task automatic testOutOfRange();
        int errStart;
        errStart = errCount;
        writeWord(`MEM_SIZE - 8, 64'hfeed_face_cafe_beef);
        readExpect(`MEM_SIZE - 7);
        writeWord(`MEM_SIZE - 6, 64'h5555_5555_5555_5555);
        readExpect(`MEM_SIZE - 1);
        readExpect(`MEM_SIZE - 8);
        reportTest("out_of_range", errStart);
    endtask

    task automatic testBackToBack();
        int                 errStart;
        logic [`ADDR_W-1:0] addrs [4];
        logic [63:0]        expData [4];
        errStart = errCount;
        addrs = '{64'h40, 64'h201, 64'h22d, 64'h305};
        for (int i = 0; i < 4; i++)
        begin
            expData[i] = modelRead(addrs[i]);
        end
        // reads on four straight edges and responses on four straight cycles
        for (int i = 0; i < 8; i++)
        begin
            @(posedge i_clk);
            if (i < 4)
            begin
                i_req <= makeReq(mem_pkg::OP_READ, addrs[i], '0);
            end
            else
            begin
                i_req.op <= mem_pkg::OP_IDLE;
            end
            @(negedge i_clk);
            if (i >= 3 && i < 7)
            begin
                checkRsp(expData[i-3], 1'b0);
            end
            else
            begin
                checkNoRsp();
            end
        end
        // read right behind the write
        sendReq(mem_pkg::OP_WRITE, 64'h40, 64'h7777_8888_9999_0000);
        readExpect(64'h40);
        reportTest("back_to_back", errStart);
    endtask

    task automatic testRandom();
        int                 errStart;
        int                 i;
        logic [`ADDR_W-1:0] addr;
        logic [63:0]        data;
        errStart = errCount;
        // known contents across the window first
        for (i = 0; i < RAND_SPAN; i += `WORD_BYTES)
        begin
            writeWord(RAND_BASE + i, {$urandom, $urandom});
        end
        for (i = 0; i < 200; i++)
        begin
            addr = RAND_BASE + ($urandom % (RAND_SPAN - 7));
            data = {$urandom, $urandom};
            if ($urandom % 2)
            begin
                writeWord(addr, data);
            end
            else
            begin
                readExpect(addr);
            end
        end
        reportTest("random", errStart);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        i_clk      = 1'b0;
        i_rstN     = 1'b0;
        i_req      = makeReq(mem_pkg::OP_IDLE, '0, '0);
        errCount   = 0;
        checkCount = 0;
        cycleCount = 0;
        void'($urandom(26));

        repeat (2) @(posedge i_clk);
        i_rstN <= 1'b1;

        testResetAligned();
        testUnaligned();
        testOverlap();
        testOutOfRange();
        testBackToBack();
        testRandom();

        repeat (4) @(posedge i_clk);
        errCount += DUT.u_props.failCount;
        $display("checks %0d, errors %0d, property failures %0d",
                 checkCount, errCount, DUT.u_props.failCount);
        if (errCount == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
design/mem_pkg.sv
design/memAddrDecode.sv
design/memBankArray.sv
design/memReadAlign.sv
design/byteMemory.sv
verif/byteMemory_props.sv
verif/byteMemory_tb.sv
